// File: hdl/exe_pkg.sv
// Shared types and constants for the branch execute stage, referenced by scoped names
package exe_pkg;

    // ------------------------------------------------------------------------
    // Widths and constants
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN = 64;          // Operand and PC width

    typedef logic [XLEN-1:0] bus64_t;

    localparam bus64_t PC_STEP    = 64'd4;                    // Fall-through increment
    localparam bus64_t JUMP_ALIGN = 64'hFFFF_FFFF_FFFF_FFFE;  // Clears bit 0 of jump targets

    // ------------------------------------------------------------------------
    // Instruction and prediction
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        NOP,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } instr_type_t;

    typedef struct packed {
        logic   is_taken;       // Predicted direction
        bus64_t pred_addr;      // Predicted target
    } bpred_t;

    // Instruction coming from register read
    typedef struct packed {
        logic        valid;
        bus64_t      pc;
        bus64_t      imm;
        bus64_t      data_rs1;
        bus64_t      data_rs2;
        logic [4:0]  rd;
        instr_type_t instr_type;
        bpred_t      bpred;
    } exe_branch_in_t;

    // Resolved outcome from the branch unit
    typedef struct packed {
        logic   taken;
        bus64_t target;
        bus64_t link;           // pc + 4
        logic   misaligned;
    } branch_res_t;

    // ------------------------------------------------------------------------
    // Exceptions, redirect and writeback
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'h0,
        NO_EXCEPTION          = 4'hF
    } exception_cause_t;

    typedef struct packed {
        logic             valid;
        exception_cause_t cause;
        bus64_t           origin;   // Faulting target address
    } exception_t;

    typedef struct packed {
        logic   valid;
        bus64_t pc;
    } redirect_t;

    typedef struct packed {
        logic       valid;
        bus64_t     pc;
        logic [4:0] rd;
        bus64_t     result;         // Link value
        bus64_t     result_pc;      // Computed target
        logic       branch_taken;
        logic       mispredict;
        exception_t ex;
    } exe_wb_t;

endpackage

// File: hdl/branch_unit.sv
// Combinational branch resolution: condition, target, link value and misalignment check
`timescale 1ns/1ps

module branch_unit (
    input  exe_pkg::exe_branch_in_t instr_i,    // Instruction from register read
    output exe_pkg::branch_res_t    res_o       // Resolved outcome
);

    exe_pkg::bus64_t rs1;
    exe_pkg::bus64_t rs2;

    logic equal;
    logic less;
    logic less_u;

    logic            taken;
    logic            is_cond;
    exe_pkg::bus64_t target;
    exe_pkg::bus64_t link;
    exe_pkg::bus64_t next_pc;

    assign rs1 = instr_i.data_rs1;
    assign rs2 = instr_i.data_rs2;

    // ------------------------------------------------------------------------
    // Comparisons
    // ------------------------------------------------------------------------
    assign equal  = (rs1 == rs2);
    assign less   = ($signed(rs1) < $signed(rs2));
    assign less_u = (rs1 < rs2);

    // ------------------------------------------------------------------------
    // Target selection
    // ------------------------------------------------------------------------
    always_comb begin
        case (instr_i.instr_type)
            exe_pkg::JAL: begin
                // PC relative, low bit forced to zero
                target = (instr_i.pc + instr_i.imm) & exe_pkg::JUMP_ALIGN;
            end
            exe_pkg::JALR: begin
                target = (rs1 + instr_i.imm) & exe_pkg::JUMP_ALIGN;  // Register relative
            end
            exe_pkg::BEQ,
            exe_pkg::BNE,
            exe_pkg::BLT,
            exe_pkg::BGE,
            exe_pkg::BLTU,
            exe_pkg::BGEU: begin
                target = instr_i.pc + instr_i.imm;
            end
            default: begin
                target = '0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Direction
    // ------------------------------------------------------------------------
    always_comb begin
        case (instr_i.instr_type)
            exe_pkg::JAL,
            exe_pkg::JALR: taken = 1'b1;      // Unconditional jumps
            exe_pkg::BEQ:  taken = equal;
            exe_pkg::BNE:  taken = ~equal;
            exe_pkg::BLT:  taken = less;
            exe_pkg::BGE:  taken = ~less;
            exe_pkg::BLTU: taken = less_u;
            exe_pkg::BGEU: taken = ~less_u;
            default:       taken = 1'b0;
        endcase
    end

    // Conditional branch types only
    assign is_cond = instr_i.instr_type inside {
        exe_pkg::BEQ, exe_pkg::BNE, exe_pkg::BLT,
        exe_pkg::BGE, exe_pkg::BLTU, exe_pkg::BGEU
    };

    // ------------------------------------------------------------------------
    // Link, next PC and alignment
    // ------------------------------------------------------------------------
    assign link    = instr_i.pc + exe_pkg::PC_STEP;
    assign next_pc = taken ? target : link;

    always_comb begin
        res_o.taken  = taken;
        res_o.target = target;
        res_o.link   = link;
        // JAL excluded, its target is checked at decode
        res_o.misaligned = (next_pc[1:0] != 2'b00) &&
                           ((instr_i.instr_type == exe_pkg::JALR) || (is_cond && taken));
    end

endmodule

// File: hdl/bpred_check.sv
// Compares the resolved branch against the fetch prediction and forms the corrected PC
`timescale 1ns/1ps

module bpred_check (
    input  exe_pkg::exe_branch_in_t instr_i,
    input  exe_pkg::branch_res_t    res_i,
    output logic                    mispredict_o,
    output exe_pkg::redirect_t      redirect_o
);

    logic            is_branch;
    logic            dir_wrong;
    logic            tgt_wrong;
    exe_pkg::bus64_t next_pc;

    assign is_branch = instr_i.valid && (instr_i.instr_type != exe_pkg::NOP);

    // Wrong direction
    assign dir_wrong = (res_i.taken != instr_i.bpred.is_taken);

    // Both taken but to different places
    assign tgt_wrong = res_i.taken && instr_i.bpred.is_taken &&
                       (res_i.target != instr_i.bpred.pred_addr);

    assign mispredict_o = is_branch && (dir_wrong || tgt_wrong);

    // Corrected fetch address
    assign next_pc = res_i.taken ? res_i.target : res_i.link;

    always_comb begin
        redirect_o.valid = mispredict_o;
        redirect_o.pc    = next_pc;
    end

endmodule

// File: hdl/branch_ctrl.sv
// Stage register for branch results: exception priority, redirect pulse and wrong-path squash
`timescale 1ns/1ps

module branch_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  exe_pkg::exe_branch_in_t instr_i,
    input  exe_pkg::branch_res_t    res_i,
    input  logic                    mispredict_i,
    input  exe_pkg::redirect_t      redirect_i,     // Carries the next PC
    output exe_pkg::exe_wb_t        wb_o,
    output exe_pkg::redirect_t      redirect_o,
    output logic                    resolved_o,     // Stats strobe, same cycle as input
    output logic                    mispredict_o
);

    logic            flush_q;       // Squashing wrong-path instructions
    exe_pkg::bus64_t flush_pc_q;    // PC that ends the squash

    logic               is_branch;
    logic               drop;
    logic               accept;
    logic               ex_hit;
    logic               mispred_eff;
    exe_pkg::exe_wb_t   wb_d;
    exe_pkg::exe_wb_t   wb_q;
    exe_pkg::redirect_t redirect_q;

    // ------------------------------------------------------------------------
    // Acceptance and priority
    // ------------------------------------------------------------------------
    assign is_branch = instr_i.valid && (instr_i.instr_type != exe_pkg::NOP);
    assign drop      = flush_q && instr_i.valid && (instr_i.pc != flush_pc_q);
    assign accept    = is_branch && !drop;

    assign ex_hit      = accept && res_i.misaligned;
    assign mispred_eff = accept && mispredict_i && !res_i.misaligned;  // Exception wins

    always_comb begin
        wb_d = '0;                          // Idle record is all zero
        if (accept) begin
            wb_d.valid        = 1'b1;
            wb_d.pc           = instr_i.pc;
            wb_d.rd           = instr_i.rd;
            wb_d.result       = res_i.link;
            wb_d.result_pc    = res_i.target;
            wb_d.branch_taken = res_i.taken;
            wb_d.mispredict   = mispred_eff;
            wb_d.ex.valid     = ex_hit;
            wb_d.ex.cause     = ex_hit ? exe_pkg::INSTR_ADDR_MISALIGNED : exe_pkg::NO_EXCEPTION;
            wb_d.ex.origin    = ex_hit ? redirect_i.pc : '0;
        end
    end

    // ------------------------------------------------------------------------
    // Stage register and squash state
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q       <= '0;
            redirect_q <= '0;
            flush_q    <= 1'b0;
            flush_pc_q <= '0;
        end else begin
            wb_q             <= wb_d;
            redirect_q.valid <= mispred_eff;
            redirect_q.pc    <= mispred_eff ? redirect_i.pc : '0;
            if (mispred_eff) begin
                flush_q    <= 1'b1;             // Start or restart the squash
                flush_pc_q <= redirect_i.pc;
            end else if (flush_q && instr_i.valid && !drop) begin
                flush_q <= 1'b0;                // Correct path has arrived
            end
        end
    end

    assign wb_o         = wb_q;
    assign redirect_o   = redirect_q;
    assign resolved_o   = accept;
    assign mispredict_o = mispred_eff;

endmodule

// File: hdl/branch_stats.sv
// Saturating event counters for resolved branches and mispredictions
`timescale 1ns/1ps

module branch_stats #(
    parameter int unsigned CNT_W = 32
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             resolved_i,
    input  logic             mispredict_i,
    output logic [CNT_W-1:0] branch_cnt_o,
    output logic [CNT_W-1:0] mispred_cnt_o
);

    logic [CNT_W-1:0] branch_cnt_q;
    logic [CNT_W-1:0] mispred_cnt_q;

    // ------------------------------------------------------------------------
    // Counters hold at all ones
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            branch_cnt_q  <= '0;
            mispred_cnt_q <= '0;
        end else begin
            if (resolved_i && (branch_cnt_q != '1)) begin
                branch_cnt_q <= branch_cnt_q + 1'b1;
            end
            if (mispredict_i && (mispred_cnt_q != '1)) begin
                mispred_cnt_q <= mispred_cnt_q + 1'b1;
            end
        end
    end

    assign branch_cnt_o  = branch_cnt_q;
    assign mispred_cnt_o = mispred_cnt_q;

endmodule

// File: hdl/branch_exe_top.sv
// Top level of the branch execute stage, connecting resolution, checking, control and stats
`timescale 1ns/1ps

module branch_exe_top #(
    parameter int unsigned CNT_W = 32   // Statistics counter width
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  exe_pkg::exe_branch_in_t instr_i,
    output exe_pkg::exe_wb_t        wb_o,
    output exe_pkg::redirect_t      redirect_o,
    output logic [CNT_W-1:0]        branch_cnt_o,
    output logic [CNT_W-1:0]        mispred_cnt_o
);

    exe_pkg::branch_res_t res;
    exe_pkg::redirect_t   redirect_comb;    // Unregistered corrected PC
    logic                 mispredict;
    logic                 resolved_ev;
    logic                 mispredict_ev;

    branch_unit u_branch_unit (
        .instr_i (instr_i),
        .res_o   (res)
    );

    bpred_check u_bpred_check (
        .instr_i      (instr_i),
        .res_i        (res),
        .mispredict_o (mispredict),
        .redirect_o   (redirect_comb)
    );

    branch_ctrl u_branch_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .res_i        (res),
        .mispredict_i (mispredict),
        .redirect_i   (redirect_comb),
        .wb_o         (wb_o),
        .redirect_o   (redirect_o),
        .resolved_o   (resolved_ev),
        .mispredict_o (mispredict_ev)
    );

    branch_stats #(
        .CNT_W (CNT_W)
    ) u_branch_stats (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .resolved_i    (resolved_ev),
        .mispredict_i  (mispredict_ev),
        .branch_cnt_o  (branch_cnt_o),
        .mispred_cnt_o (mispred_cnt_o)
    );

endmodule

// File: dv/tb_branch_ref.svh
// Reference model and compare tasks of the branch execute testbench, included in its top module

// Expected writeback and redirect of an accepted instruction
function automatic void ref_branch(
    input  exe_pkg::exe_branch_in_t x,
    output exe_pkg::exe_wb_t        wb_out,
    output exe_pkg::redirect_t      rdr_out
);
    exe_pkg::bus64_t sum;
    exe_pkg::bus64_t target;
    exe_pkg::bus64_t link;
    exe_pkg::bus64_t next_pc;
    logic            lt_s;
    logic            lt_u;
    logic            taken;
    logic            cond;
    logic            bad_align;
    logic            wrong;

    sum  = x.pc + x.imm;
    link = x.pc + 64'd4;
    lt_u = (x.data_rs1 < x.data_rs2);
    // Signs differ so the negative operand is smaller
    lt_s = (x.data_rs1[63] != x.data_rs2[63]) ? x.data_rs1[63] : lt_u;
    cond   = 1'b1;
    target = sum;
    case (x.instr_type)
        exe_pkg::BEQ:  taken = (x.data_rs1 == x.data_rs2);
        exe_pkg::BNE:  taken = (x.data_rs1 != x.data_rs2);
        exe_pkg::BLT:  taken = lt_s;
        exe_pkg::BGE:  taken = !lt_s;
        exe_pkg::BLTU: taken = lt_u;
        exe_pkg::BGEU: taken = !lt_u;
        default: begin                      // JAL and JALR
            cond   = 1'b0;
            taken  = 1'b1;
            target = (x.instr_type == exe_pkg::JALR) ? x.data_rs1 + x.imm : sum;
            target[0] = 1'b0;
        end
    endcase

    next_pc   = taken ? target : link;
    bad_align = (next_pc[1:0] != 2'b00) && ((x.instr_type == exe_pkg::JALR) || (cond && taken));
    wrong     = (taken != x.bpred.is_taken) ||
                (taken && x.bpred.is_taken && (target != x.bpred.pred_addr));

    wb_out              = '0;
    wb_out.valid        = 1'b1;
    wb_out.pc           = x.pc;
    wb_out.rd           = x.rd;
    wb_out.result       = link;
    wb_out.result_pc    = target;
    wb_out.branch_taken = taken;
    wb_out.mispredict   = wrong && !bad_align;     // Exception suppresses it
    wb_out.ex.valid     = bad_align;
    wb_out.ex.cause     = bad_align ? exe_pkg::INSTR_ADDR_MISALIGNED : exe_pkg::NO_EXCEPTION;
    wb_out.ex.origin    = bad_align ? next_pc : '0;
    rdr_out.valid       = wb_out.mispredict;
    rdr_out.pc          = wb_out.mispredict ? next_pc : '0;
endfunction

// ------------------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------------------
task automatic check_wb(input string name, input exe_pkg::exe_wb_t exp,
                        input exe_pkg::exe_wb_t act);
    if (act !== exp) begin
        $display("[ERROR] %s wb_o expected %h actual %h", name, exp, act);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    end
endtask

task automatic check_redirect(input string name, input exe_pkg::redirect_t exp,
                              input exe_pkg::redirect_t act);
    if (act !== exp) begin
        $display("[ERROR] %s redirect_o expected %h actual %h", name, exp, act);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    end
endtask

task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                           input logic [CNT_W-1:0] act);
    if (act !== exp) begin
        $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    end
endtask

// File: dv/tb_branch_exe.sv
// Testbench driving directed and random branches into the branch execute stage, checked each cycle
`timescale 1ns/1ps

module tb_branch_exe;

    localparam int unsigned CNT_W        = 32;
    localparam int unsigned CLK_PERIOD   = 100;
    localparam int unsigned RESET_CYCLES = 10;
    localparam int unsigned COND_CASES   = 12;
    // Each test instruction may be followed by one recovery instruction
    localparam int unsigned TEST_CYCLES     = 2 * (6 * COND_CASES + 30) + 30;
    localparam int unsigned WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;

    logic                    clk;
    logic                    rst_n;
    exe_pkg::exe_branch_in_t instr;
    exe_pkg::exe_wb_t        wb_dut;
    exe_pkg::redirect_t      redirect_dut;
    logic [CNT_W-1:0]        branch_cnt;
    logic [CNT_W-1:0]        mispred_cnt;

    integer                  seed;
    string                   cur_name;      // Test of the instruction now driven
    exe_pkg::exe_wb_t        exp_wb;
    exe_pkg::redirect_t      exp_rd;
    logic                    flush_m;       // Squash state model
    exe_pkg::bus64_t         flush_pc_m;
    logic [CNT_W-1:0]        n_branch;
    logic [CNT_W-1:0]        n_mispred;

    `include "tb_branch_ref.svh"

    branch_exe_top #(
        .CNT_W (CNT_W)
    ) u_dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_i       (instr),
        .wb_o          (wb_dut),
        .redirect_o    (redirect_dut),
        .branch_cnt_o  (branch_cnt),
        .mispred_cnt_o (mispred_cnt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    function automatic exe_pkg::bus64_t random_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic exe_pkg::exe_branch_in_t make_instr(
        input exe_pkg::instr_type_t t, input exe_pkg::bus64_t pc, input exe_pkg::bus64_t imm,
        input exe_pkg::bus64_t rs1, input exe_pkg::bus64_t rs2,
        input logic p_taken, input exe_pkg::bus64_t p_addr);
        exe_pkg::exe_branch_in_t x;
        int                      rd_bits;
        rd_bits         = $random(seed);
        x               = '0;
        x.valid         = 1'b1;
        x.pc            = pc;
        x.imm           = imm;
        x.data_rs1      = rs1;
        x.data_rs2      = rs2;
        x.rd            = rd_bits[4:0];
        x.instr_type    = t;
        x.bpred.is_taken  = p_taken;
        x.bpred.pred_addr = p_addr;
        return x;
    endfunction

    function automatic exe_pkg::exe_branch_in_t with_right_pred(input exe_pkg::exe_branch_in_t x);
        exe_pkg::exe_wb_t        wb_e;
        exe_pkg::redirect_t      rd_e;
        exe_pkg::exe_branch_in_t y;
        ref_branch(x, wb_e, rd_e);
        y                 = x;
        y.bpred.is_taken  = wb_e.branch_taken;
        y.bpred.pred_addr = wb_e.result_pc;
        return y;
    endfunction

    // Drives one input and updates the expected outputs, squash model and counts
    task automatic apply_instr(input string name, input exe_pkg::exe_branch_in_t x);
        exe_pkg::exe_wb_t   wb_e;
        exe_pkg::redirect_t rd_e;
        logic               drop;
        logic               accept;
        @(posedge clk);
        #1;
        drop   = flush_m && x.valid && (x.pc != flush_pc_m);
        accept = x.valid && (x.instr_type != exe_pkg::NOP) && !drop;
        wb_e   = '0;
        rd_e   = '0;
        if (accept) begin
            ref_branch(x, wb_e, rd_e);
            n_branch += 1;
            if (wb_e.mispredict) begin
                n_mispred += 1;
            end
        end
        if (rd_e.valid) begin
            flush_m    = 1'b1;
            flush_pc_m = rd_e.pc;
        end else if (flush_m && x.valid && !drop) begin
            flush_m = 1'b0;                     // Correct path reached
        end
        instr    = x;
        exp_wb   = wb_e;
        exp_rd   = rd_e;
        cur_name = name;
    endtask

    // Ends a pending squash with a correctly predicted not-taken branch
    task automatic recover_path();
        if (flush_m) begin
            apply_instr("path recovery", make_instr(exe_pkg::BNE, flush_pc_m, 64'h10,
                                                    64'd5, 64'd5, 1'b0, 64'h0));
        end
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic conditional_sweep();
        exe_pkg::instr_type_t types [6];
        exe_pkg::bus64_t      pc;
        exe_pkg::bus64_t      imm;
        exe_pkg::bus64_t      rs1;
        exe_pkg::bus64_t      rs2;
        types = '{exe_pkg::BEQ, exe_pkg::BNE, exe_pkg::BLT,
                  exe_pkg::BGE, exe_pkg::BLTU, exe_pkg::BGEU};
        foreach (types[t]) begin
            for (int c = 0; c < COND_CASES; c++) begin
                pc  = random_word() & ~64'h3;
                imm = random_word();
                imm = {{51{imm[12]}}, imm[12:1], 1'b0};     // Bit 1 may break alignment
                rs1 = random_word();
                rs2 = random_word();
                case (c)
                    0: rs2 = rs1;
                    1: begin
                        rs1 = rs1 | 64'h8000_0000_0000_0000;
                        rs2 = rs2 & 64'h7FFF_FFFF_FFFF_FFFF;
                    end
                    2: begin
                        rs1 = '0;
                        rs2 = '1;
                    end
                    3: begin
                        rs1 = '1;
                        rs2 = '0;
                    end
                    4: begin
                        rs1 = 64'h8000_0000_0000_0000;
                        rs2 = 64'h7FFF_FFFF_FFFF_FFFF;
                    end
                    default: ;
                endcase
                apply_instr($sformatf("%s case %0d", types[t].name(), c),
                            make_instr(types[t], pc, imm, rs1, rs2, c[0],
                                       (c % 3 == 0) ? random_word() : pc + imm));
                recover_path();
            end
        end
    endtask

    task automatic jump_targets();
        exe_pkg::bus64_t pc;
        exe_pkg::bus64_t base;
        pc   = random_word() & ~64'h3;
        base = random_word() & ~64'h3;
        apply_instr("jal odd offset", with_right_pred(make_instr(exe_pkg::JAL, pc, 64'h101,
                    64'h0, 64'h0, 1'b0, 64'h0)));
        apply_instr("jal predicted not taken", make_instr(exe_pkg::JAL, pc,
                    64'hFFFF_FFFF_FFFF_FFF9, 64'h0, 64'h0, 1'b0, 64'h0));
        recover_path();
        apply_instr("jal target bit 1", with_right_pred(make_instr(exe_pkg::JAL, pc, 64'h102,
                    64'h0, 64'h0, 1'b0, 64'h0)));
        apply_instr("jalr odd sum", with_right_pred(make_instr(exe_pkg::JALR, pc, 64'h11,
                    base, 64'h0, 1'b0, 64'h0)));
        apply_instr("jalr wrong target", make_instr(exe_pkg::JALR, pc, 64'h11, base, 64'h0,
                    1'b1, base));
        recover_path();
        // Sum ends in binary 11 so the cleared target still has bit 1 set
        apply_instr("jalr misaligned mispredicted", make_instr(exe_pkg::JALR, pc, 64'h3,
                    base, 64'h0, 1'b0, 64'h0));
        apply_instr("jalr misaligned predicted", with_right_pred(make_instr(exe_pkg::JALR,
                    pc, 64'h2, base | 64'h1, 64'h0, 1'b0, 64'h0)));
        for (int i = 0; i < 4; i++) begin
            apply_instr($sformatf("jalr random %0d", i), make_instr(exe_pkg::JALR, pc,
                        random_word(), random_word(), 64'h0, i[0], random_word()));
            recover_path();
        end
    endtask

    task automatic prediction_cases();
        exe_pkg::bus64_t pc;
        pc = random_word() & ~64'h3;
        apply_instr("correct taken", make_instr(exe_pkg::BEQ, pc, 64'h80, 64'd7, 64'd7,
                    1'b1, pc + 64'h80));
        recover_path();
        apply_instr("taken predicted not taken", make_instr(exe_pkg::BEQ, pc, 64'h80,
                    64'd7, 64'd7, 1'b0, 64'h0));
        recover_path();
        apply_instr("not taken predicted taken", make_instr(exe_pkg::BNE, pc, 64'h80,
                    64'd7, 64'd7, 1'b1, pc + 64'h80));
        recover_path();
        apply_instr("taken wrong target", make_instr(exe_pkg::BLT, pc, 64'h80, '1, 64'd1,
                    1'b1, pc + 64'h100));
        recover_path();
        apply_instr("not taken stale target", make_instr(exe_pkg::BGEU, pc, 64'h80, 64'd0,
                    64'd1, 1'b0, random_word()));
        recover_path();
    endtask

    task automatic wrong_path_squash();
        exe_pkg::bus64_t pc;
        pc = random_word() & ~64'h3;
        apply_instr("squash trigger", make_instr(exe_pkg::BEQ, pc, 64'h40, 64'd3, 64'd3,
                    1'b0, 64'h0));
        apply_instr("wrong path 1", with_right_pred(make_instr(exe_pkg::BNE, pc + 64'h4,
                    64'h20, 64'd1, 64'd2, 1'b0, 64'h0)));
        apply_instr("wrong path nop", make_instr(exe_pkg::NOP, pc + 64'hC, 64'h0, 64'h0,
                    64'h0, 1'b0, 64'h0));
        apply_instr("invalid during squash", '0);
        // Still squashing after the nop and the idle cycle
        apply_instr("wrong path 2", make_instr(exe_pkg::BLT, pc + 64'h8, 64'h20, 64'd1,
                    64'd2, 1'b0, 64'h0));
        // Matching pc mispredicts again and restarts the squash
        apply_instr("correct path", make_instr(exe_pkg::BGE, pc + 64'h40, 64'h10, 64'd1,
                    64'd2, 1'b1, pc + 64'h50));
        apply_instr("wrong path after restart", make_instr(exe_pkg::BEQ, pc + 64'h50,
                    64'h8, 64'd1, 64'd1, 1'b0, 64'h0));
        recover_path();
    endtask

    task automatic idle_inputs();
        exe_pkg::exe_branch_in_t x;
        apply_instr("valid nop", make_instr(exe_pkg::NOP, random_word(), random_word(),
                    random_word(), random_word(), 1'b1, random_word()));
        x       = make_instr(exe_pkg::BEQ, random_word(), 64'h8, 64'd1, 64'd1, 1'b0, 64'h0);
        x.valid = 1'b0;
        apply_instr("invalid branch", x);
        apply_instr("idle", '0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence, comparison and watchdog
    // ------------------------------------------------------------------------
    initial begin : main_sequence
        seed       = 73;
        clk        = 1'b0;
        rst_n      = 1'b0;
        instr      = '0;
        cur_name   = "reset";
        exp_wb     = '0;
        exp_rd     = '0;
        flush_m    = 1'b0;
        flush_pc_m = '0;
        n_branch   = '0;
        n_mispred  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_count("branch count after reset", '0, branch_cnt);
        check_count("mispredict count after reset", '0, mispred_cnt);
        conditional_sweep();
        jump_targets();
        prediction_cases();
        wrong_path_squash();
        idle_inputs();
        apply_instr("drain", '0);
        apply_instr("drain", '0);
        @(posedge clk);
        #20;
        check_count("final branch count", n_branch, branch_cnt);
        check_count("final mispredict count", n_mispred, mispred_cnt);
        $display("Simulation passed");
        $finish;
    end

    // Latches the expectation at the capturing edge, compares at the falling edge
    initial begin : compare_outputs
        string              name;
        exe_pkg::exe_wb_t   wb_e;
        exe_pkg::redirect_t rd_e;
        forever begin
            @(posedge clk);
            name = cur_name;
            wb_e = exp_wb;
            rd_e = exp_rd;
            @(negedge clk);
            check_wb(name, wb_e, wb_dut);
            check_redirect(name, rd_e, redirect_dut);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: project.f
+incdir+dv
hdl/exe_pkg.sv
hdl/branch_unit.sv
hdl/bpred_check.sv
hdl/branch_ctrl.sv
hdl/branch_stats.sv
hdl/branch_exe_top.sv
dv/tb_branch_exe.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_branch_exe -f project.f

sim_out=$(./obj_dir/Vtb_branch_exe 2>&1) || true
printf '%s\n' "$sim_out"

# Exit status of the script follows the search
printf '%s\n' "$sim_out" | grep -qx "Simulation passed"
